// File: hdl/wcs_pkg.sv
package wcs_pkg;

  // Micro address, bit 12 picks the bank
  localparam int UA_W    = 13;
  localparam int BANK_AW = 12;  // 4K words per bank

  // A microword is loaded as four 16-bit lanes
  localparam int LANE_W  = 16;
  localparam int N_LANES = 4;

  // Loader register map, byte offsets
  localparam logic [11:0] REG_CTRL = 12'h000;
  localparam logic [11:0] REG_ADDR = 12'h004;
  localparam logic [11:0] REG_DATA = 12'h008;

  // APB request from the master
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } apb_rsp_t;

  // Decoded microinstruction layout, msb first
  typedef struct packed {
    logic [12:0] next_addr;  // Branch target
    logic [4:0]  cond_sel;   // Test condition for the sequencer
    logic [5:0]  alu_op;
    logic [4:0]  src_a;
    logic [4:0]  src_b;
    logic [4:0]  dest;
    logic [24:0] misc;       // Remaining control bits
  } cs_fields_t;

  // Loader sees lanes, sequencer sees fields
  typedef union packed {
    logic [N_LANES-1:0][LANE_W-1:0] lanes;  // Lane 0 in bits 15..0
    cs_fields_t                     fields;
  } cs_word_u;

  typedef struct packed {
    logic            valid;
    logic [UA_W-1:0] ua;
  } fetch_req_t;

  typedef struct packed {
    logic     valid;
    cs_word_u word;
  } fetch_rsp_t;

  // Single command port into the store
  typedef struct packed {
    logic               en;
    logic [UA_W-1:0]    ua;
    logic [N_LANES-1:0] lane_we;  // Zero for a read
    cs_word_u           wdata;
  } store_cmd_t;

endpackage

// File: hdl/wcs_bank.sv
`timescale 1ns/1ps

module wcs_bank #(
  parameter int AW = wcs_pkg::BANK_AW
) (
  input  logic              sysclk,
  input  logic              en,       // Bank enable, read and write
  input  logic [AW-1:0]     addr,     // Word address inside the bank
  input  logic [3:0]        lane_we,  // One write strobe per 16-bit lane
  input  wcs_pkg::cs_word_u wdata,
  output wcs_pkg::cs_word_u rdata
);
  import wcs_pkg::*;

  // 64-bit words stored as lanes so each strobe hits its own slice
  logic [N_LANES-1:0][LANE_W-1:0] mem [2**AW];

  // Lane writes
  always_ff @(posedge sysclk) begin
    if (en) begin
      for (int i = 0; i < N_LANES; i++) begin
        if (lane_we[i]) begin
          mem[addr][i] <= wdata.lanes[i];  // Only the strobed lane changes
        end
      end
    end
  end

  // Registered read, word appears one cycle after the address
  always_ff @(posedge sysclk) begin
    if (en) begin
      rdata.lanes <= mem[addr];  // Old contents on a write cycle
    end
  end

  // Loader only ever writes a single lane per access
  a_one_lane: assert property (@(posedge sysclk) en |-> $onehot0(lane_we))
    else $error("wcs_bank: more than one lane strobe set");

endmodule

// File: hdl/wcs_store.sv
`timescale 1ns/1ps

module wcs_store #(
  parameter int AW = wcs_pkg::BANK_AW
) (
  input  logic                sysclk,
  input  logic                rst,
  input  wcs_pkg::store_cmd_t cmd,
  output wcs_pkg::cs_word_u   rdata
);
  import wcs_pkg::*;

  logic               upper;     // Bank bit of the current command
  logic               upper_q;   // Bank bit of the read in flight
  logic               en_lower;
  logic               en_upper;
  logic [N_LANES-1:0] we_lower;
  logic [N_LANES-1:0] we_upper;
  cs_word_u           rdata_lower;
  cs_word_u           rdata_upper;

  assign upper = cmd.ua[UA_W-1];  // 0x0000-0x0FFF lower, 0x1000-0x1FFF upper

  // Enables and strobes only reach the addressed bank
  assign en_lower = cmd.en & ~upper;
  assign en_upper = cmd.en & upper;
  assign we_lower = cmd.lane_we & {N_LANES{en_lower}};
  assign we_upper = cmd.lane_we & {N_LANES{en_upper}};

  // Remember which bank was read so the mux lines up with the registered data
  always_ff @(posedge sysclk) begin
    if (rst) begin
      upper_q <= 1'b0;
    end else if (cmd.en) begin
      upper_q <= upper;
    end
  end

  assign rdata = upper_q ? rdata_upper : rdata_lower;  // Bank select mux

  wcs_bank #(.AW(AW)) bank_lower (
    .sysclk  (sysclk),
    .en      (en_lower),
    .addr    (cmd.ua[AW-1:0]),
    .lane_we (we_lower),
    .wdata   (cmd.wdata),
    .rdata   (rdata_lower)
  );

  wcs_bank #(.AW(AW)) bank_upper (
    .sysclk  (sysclk),
    .en      (en_upper),
    .addr    (cmd.ua[AW-1:0]),
    .lane_we (we_upper),
    .wdata   (cmd.wdata),
    .rdata   (rdata_upper)
  );

endmodule

// File: hdl/wcs_addr_counter.sv
`timescale 1ns/1ps

module wcs_addr_counter (
  input  logic        sysclk,
  input  logic        rst,
  input  logic        set,       // Load from an ADDR register write
  input  logic [12:0] set_ua,
  input  logic [1:0]  set_lane,
  input  logic        step,      // One completed DATA access
  output logic [12:0] ua,        // Current word address
  output logic [1:0]  lane       // Current lane inside the word
);
  import wcs_pkg::*;

  logic last_lane;

  assign last_lane = (lane == 2'(N_LANES - 1));

  // Lane moves first, word address follows on lane wrap
  always_ff @(posedge sysclk) begin
    if (rst) begin
      ua   <= '0;
      lane <= '0;
    end else if (set) begin
      ua   <= set_ua;
      lane <= set_lane;
    end else if (step) begin
      if (last_lane) begin
        lane <= '0;
        ua   <= ua + 13'd1;  // 0x1FFF rolls over to 0
      end else begin
        lane <= lane + 2'd1;
      end
    end
  end

  // FSM never completes an ADDR write and a DATA access in one cycle
  a_set_xor_step: assert property (@(posedge sysclk) disable iff (rst) !(set && step))
    else $error("wcs_addr_counter: set and step together");

endmodule

// File: hdl/wcs_load_fsm.sv
`timescale 1ns/1ps

module wcs_load_fsm (
  input  logic                sysclk,
  input  logic                rst,
  input  wcs_pkg::apb_req_t   apb_req,
  output wcs_pkg::apb_rsp_t   apb_rsp,
  input  logic [12:0]         ua,         // From the address counter
  input  logic [1:0]          lane,
  input  wcs_pkg::cs_word_u   rdata,      // Store read data
  output logic                load_mode,
  output logic                cnt_set,
  output logic [12:0]         cnt_set_ua,
  output logic [1:0]          cnt_set_lane,
  output logic                cnt_step,
  output wcs_pkg::store_cmd_t load_cmd
);
  import wcs_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    READ_WAIT
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   setup_ph;   // psel without penable
  logic   is_ctrl;
  logic   is_addr;
  logic   is_data;
  logic   data_ok;    // DATA access allowed, store owned by loader
  logic   ctrl_wr;

  assign setup_ph = apb_req.psel & ~apb_req.penable;
  assign is_ctrl  = (apb_req.paddr == REG_CTRL);
  assign is_addr  = (apb_req.paddr == REG_ADDR);
  assign is_data  = (apb_req.paddr == REG_DATA);
  assign data_ok  = is_data & load_mode;

  // ADDR write layout, word in 12..0 and lane in 17..16
  assign cnt_set_ua   = apb_req.pwdata[UA_W-1:0];
  assign cnt_set_lane = apb_req.pwdata[17:16];

  always_comb begin
    state_nxt            = state;
    apb_rsp              = '0;
    cnt_set              = 1'b0;
    cnt_step             = 1'b0;
    ctrl_wr              = 1'b0;
    load_cmd             = '0;
    load_cmd.ua          = ua;
    load_cmd.wdata.lanes = {N_LANES{apb_req.pwdata[LANE_W-1:0]}};  // Strobe picks the lane
    case (state)
      IDLE: begin
        if (setup_ph) begin
          state_nxt = ACCESS;
        end
      end
      ACCESS: begin
        if (!apb_req.psel) begin
          state_nxt = IDLE;  // Master abandoned the transfer
        end else if (apb_req.penable) begin
          if (apb_req.pwrite || !data_ok) begin
            // Zero wait state completion
            apb_rsp.pready  = 1'b1;
            apb_rsp.pslverr = !(is_ctrl || is_addr || data_ok);
            state_nxt       = IDLE;
            if (apb_req.pwrite) begin
              ctrl_wr          = is_ctrl;
              cnt_set          = is_addr;
              cnt_step         = data_ok;
              load_cmd.en      = data_ok;
              load_cmd.lane_we = data_ok ? (4'b0001 << lane) : 4'b0000;
            end else if (is_ctrl) begin
              apb_rsp.prdata = {31'b0, load_mode};
            end else if (is_addr) begin
              apb_rsp.prdata = {14'b0, lane, 3'b0, ua};
            end
          end else begin
            load_cmd.en = 1'b1;  // Issue bank read, answer next cycle
            state_nxt   = READ_WAIT;
          end
        end
      end
      READ_WAIT: begin
        apb_rsp.pready = 1'b1;
        apb_rsp.prdata = {16'b0, rdata.lanes[lane]};  // Lane still unchanged here
        cnt_step       = 1'b1;
        state_nxt      = IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge sysclk) begin
    if (rst) begin
      state     <= IDLE;
      load_mode <= 1'b0;
    end else begin
      state <= state_nxt;
      if (ctrl_wr) begin
        load_mode <= apb_req.pwdata[0];
      end
    end
  end

  // Master must still hold the access phase when the slave answers
  a_pready_in_access: assert property (@(posedge sysclk) disable iff (rst)
    apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
    else $error("wcs_load_fsm: pready outside the access phase");

endmodule

// File: hdl/wcs_top.sv
`timescale 1ns/1ps

module wcs_top #(
  parameter int AW = wcs_pkg::BANK_AW
) (
  input  logic                sysclk,
  input  logic                rst,
  input  wcs_pkg::apb_req_t   apb_req,
  output wcs_pkg::apb_rsp_t   apb_rsp,
  input  wcs_pkg::fetch_req_t fetch_req,  // Microsequencer side
  output wcs_pkg::fetch_rsp_t fetch_rsp
);
  import wcs_pkg::*;

  logic            load_mode;
  logic            cnt_set;
  logic            cnt_step;
  logic [UA_W-1:0] cnt_set_ua;
  logic [1:0]      cnt_set_lane;
  logic [UA_W-1:0] ua;
  logic [1:0]      lane;
  logic            fetch_valid_q;
  store_cmd_t      load_cmd;
  store_cmd_t      fetch_cmd;
  store_cmd_t      store_cmd;
  cs_word_u        store_rdata;

  // Fetch is a plain read of the addressed word
  always_comb begin
    fetch_cmd    = '0;
    fetch_cmd.en = fetch_req.valid;
    fetch_cmd.ua = fetch_req.ua;
  end

  assign store_cmd = load_mode ? load_cmd : fetch_cmd;  // Loader owns the store in load mode

  always_ff @(posedge sysclk) begin
    if (rst) begin
      fetch_valid_q <= 1'b0;
    end else begin
      fetch_valid_q <= fetch_req.valid & ~load_mode;  // Requests dropped while loading
    end
  end

  assign fetch_rsp = '{valid: fetch_valid_q, word: store_rdata};

  wcs_load_fsm u_load_fsm (
    .sysclk       (sysclk),
    .rst          (rst),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .ua           (ua),
    .lane         (lane),
    .rdata        (store_rdata),
    .load_mode    (load_mode),
    .cnt_set      (cnt_set),
    .cnt_set_ua   (cnt_set_ua),
    .cnt_set_lane (cnt_set_lane),
    .cnt_step     (cnt_step),
    .load_cmd     (load_cmd)
  );

  wcs_addr_counter u_addr_counter (
    .sysclk   (sysclk),
    .rst      (rst),
    .set      (cnt_set),
    .set_ua   (cnt_set_ua),
    .set_lane (cnt_set_lane),
    .step     (cnt_step),
    .ua       (ua),
    .lane     (lane)
  );

  wcs_store #(.AW(AW)) u_store (
    .sysclk (sysclk),
    .rst    (rst),
    .cmd    (store_cmd),
    .rdata  (store_rdata)
  );

endmodule

// File: verification/wcs_tb_tests.svh
// Directed tests for the wcs_tb module body

task automatic test_reset_state();
  fetch_rsp_t none;
  apb_rsp_t   idle;
  none = '0;
  idle = '0;
  begin_test("reset_state");
  reg_read("ctrl after reset", REG_CTRL, 32'h0, 1'b0, 0);
  reg_read("addr after reset", REG_ADDR, 32'h0, 1'b0, 0);
  repeat (3) begin
    @(negedge clk);
    check_apb_rsp("idle apb", apb_rsp, idle, 1'b1);  // Bus idle so no pready
    check_fetch("idle fetch", fetch_rsp, none);  // No request gives no response
  end
  end_test();
endtask

task automatic test_lane_load();
  begin_test("lane_load");
  word_10 = rand_word();
  word_11 = rand_word();
  reg_write("ctrl load on", REG_CTRL, 32'h1, 1'b0);
  load_word(13'h0010, word_10);
  for (int i = 0; i < N_LANES; i++) begin
    reg_write($sformatf("data lane %0d", i), REG_DATA, {16'h0, word_11.lanes[i]}, 1'b0);
  end
  reg_read("addr after 8 lanes", REG_ADDR, addr_value(13'h0012, 2'd0), 1'b0, 0);
  reg_write("ctrl load off", REG_CTRL, 32'h0, 1'b0);
  fetch_ua[0] = 13'h0010;
  fetch_ua[1] = 13'h0011;
  fetch_run(2);
  check_fetch("fetch 0x0010", fetch_got[0], valid_rsp(word_10));
  check_fetch("fetch 0x0011", fetch_got[1], valid_rsp(word_11));
  end_test();
endtask

task automatic test_bank_split();
  begin_test("bank_split");
  word_lo = rand_word();
  word_hi = rand_word();
  reg_write("ctrl load on", REG_CTRL, 32'h1, 1'b0);
  load_word(13'h0005, word_lo);  // Same bank offset in the other bank
  load_word(13'h1005, word_hi);
  reg_write("ctrl load off", REG_CTRL, 32'h0, 1'b0);
  fetch_ua[0] = 13'h0005;
  fetch_ua[1] = 13'h1005;
  fetch_run(2);
  check_fetch("fetch 0x0005", fetch_got[0], valid_rsp(word_lo));
  check_fetch("fetch 0x1005", fetch_got[1], valid_rsp(word_hi));
  // Field view rebuilt from the written lanes with lane 3 on top
  check_word("fields 0x0005", fetch_got[0].word, fields_from_raw(
    {word_lo.lanes[3], word_lo.lanes[2], word_lo.lanes[1], word_lo.lanes[0]}));
  check_word("fields 0x1005", fetch_got[1].word, fields_from_raw(
    {word_hi.lanes[3], word_hi.lanes[2], word_hi.lanes[1], word_hi.lanes[0]}));
  end_test();
endtask

task automatic test_readback();
  begin_test("readback");
  reg_write("ctrl load on", REG_CTRL, 32'h1, 1'b0);
  reg_write("addr 0x0005", REG_ADDR, addr_value(13'h0005, 2'd0), 1'b0);
  for (int i = 0; i < N_LANES; i++) begin
    reg_read($sformatf("read lane %0d", i), REG_DATA, {16'h0, word_lo.lanes[i]}, 1'b0, 1);
  end
  reg_read("addr after reads", REG_ADDR, addr_value(13'h0006, 2'd0), 1'b0, 0);
  reg_write("ctrl load off", REG_CTRL, 32'h0, 1'b0);
  end_test();
endtask

task automatic test_protection();
  fetch_rsp_t none;
  none = '0;
  begin_test("protection");
  reg_write("addr 0x0010", REG_ADDR, addr_value(13'h0010, 2'd0), 1'b0);
  reg_write("data write blocked", REG_DATA, 32'h0000dead, 1'b1);
  reg_read("addr not stepped", REG_ADDR, addr_value(13'h0010, 2'd0), 1'b0, 0);
  reg_read("data read blocked", REG_DATA, 32'h0, 1'b1, 0);
  reg_write("bad offset write", 12'h00c, 32'h1, 1'b1);
  reg_read("bad offset read", 12'h00c, 32'h0, 1'b1, 0);
  fetch_ua[0] = 13'h0010;
  fetch_run(1);
  check_fetch("word 0x0010 kept", fetch_got[0], valid_rsp(word_10));
  reg_write("ctrl load on", REG_CTRL, 32'h1, 1'b0);
  fetch_run(1);
  check_fetch("fetch in load mode", fetch_got[0], none);  // Ignored while loading
  reg_write("ctrl load off", REG_CTRL, 32'h0, 1'b0);
  end_test();
endtask

task automatic test_addr_wrap();
  logic [31:0] r;
  begin_test("addr_wrap");
  r = rand32();
  reg_write("ctrl load on", REG_CTRL, 32'h1, 1'b0);
  reg_write("addr 0x1fff lane 3", REG_ADDR, addr_value(13'h1fff, 2'd3), 1'b0);
  reg_write("data last lane", REG_DATA, {16'h0, r[15:0]}, 1'b0);
  reg_read("addr wrapped", REG_ADDR, addr_value(13'h0000, 2'd0), 1'b0, 0);
  reg_write("addr 0x1fff lane 3", REG_ADDR, addr_value(13'h1fff, 2'd3), 1'b0);
  reg_read("read last lane", REG_DATA, {16'h0, r[15:0]}, 1'b0, 1);  // Upper bank readback
  reg_read("addr wrapped again", REG_ADDR, addr_value(13'h0000, 2'd0), 1'b0, 0);
  reg_write("ctrl load off", REG_CTRL, 32'h0, 1'b0);
  end_test();
endtask

// File: verification/wcs_tb.sv
`timescale 1ns/1ps

module wcs_tb;
  import wcs_pkg::*;

  localparam int MAX_CYCLES = 4000;  // Bound for the whole run with margin over the tests

  logic       clk;
  logic       rst;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  fetch_req_t fetch_req;
  fetch_rsp_t fetch_rsp;

  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          err_at_start = 0;
  int          cycles = 0;
  string       test_name;
  logic [31:0] rng_state = 32'hba38ef83;

  logic [12:0] fetch_ua [4];   // Addresses for fetch_run
  fetch_rsp_t  fetch_got [4];  // One response per address

  cs_word_u word_10;  // Words kept across tests
  cs_word_u word_11;
  cs_word_u word_lo;
  cs_word_u word_hi;

  wcs_top #(.AW(BANK_AW)) dut0 (
    .sysclk    (clk),
    .rst       (rst),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // Run limit
  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic cs_word_u rand_word();
    cs_word_u    w;
    logic [31:0] r;
    for (int i = 0; i < N_LANES; i++) begin
      r = rand32();
      w.lanes[i] = r[15:0];
    end
    return w;
  endfunction

  // ADDR register image with the word in 12..0 and the lane in 17..16
  function automatic logic [31:0] addr_value(input logic [12:0] ua, input logic [1:0] lane);
    logic [31:0] v;
    v        = 32'h0;
    v[12:0]  = ua;    // Word address
    v[17:16] = lane;  // Lane pointer
    return v;
  endfunction

  // Field layout taken straight from the bit positions with msb first
  function automatic cs_word_u fields_from_raw(input logic [63:0] raw);
    cs_word_u w;
    w.fields.next_addr = raw[63:51];
    w.fields.cond_sel  = raw[50:46];
    w.fields.alu_op    = raw[45:40];
    w.fields.src_a     = raw[39:35];
    w.fields.src_b     = raw[34:30];
    w.fields.dest      = raw[29:25];
    w.fields.misc      = raw[24:0];
    return w;
  endfunction

  function automatic fetch_rsp_t valid_rsp(input cs_word_u w);
    fetch_rsp_t r;
    r.valid = 1'b1;
    r.word  = w;
    return r;
  endfunction

  task automatic check_apb_rsp(input string name, input apb_rsp_t got, input apb_rsp_t exp,
                               input bit cmp_data);
    checks++;
    if (got.pready !== exp.pready || got.pslverr !== exp.pslverr ||
        (cmp_data && got.prdata !== exp.prdata)) begin
      errors++;
      $display("CHECK FAILED %s apb_rsp: got pready=%h pslverr=%h prdata=%h", name,
               got.pready, got.pslverr, got.prdata);
      $display("  expected pready=%h pslverr=%h prdata=%h", exp.pready, exp.pslverr,
               exp.prdata);
    end
  endtask

  task automatic check_word(input string name, input cs_word_u got, input cs_word_u exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s word: got lanes %h expected %h", name, got.lanes, exp.lanes);
      $display("  got next_addr=%h cond_sel=%h alu_op=%h src_a=%h src_b=%h dest=%h misc=%h",
               got.fields.next_addr, got.fields.cond_sel, got.fields.alu_op,
               got.fields.src_a, got.fields.src_b, got.fields.dest, got.fields.misc);
      $display("  exp next_addr=%h cond_sel=%h alu_op=%h src_a=%h src_b=%h dest=%h misc=%h",
               exp.fields.next_addr, exp.fields.cond_sel, exp.fields.alu_op,
               exp.fields.src_a, exp.fields.src_b, exp.fields.dest, exp.fields.misc);
    end
  endtask

  task automatic check_fetch(input string name, input fetch_rsp_t got, input fetch_rsp_t exp);
    checks++;
    if (got.valid !== exp.valid) begin
      errors++;
      $display("CHECK FAILED %s fetch_rsp.valid: got %h expected %h", name, got.valid,
               exp.valid);
    end else if (exp.valid) begin
      check_word(name, got.word, exp.word);  // Word only means something when valid
    end
  endtask

  task automatic check_waits(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED %s wait_states: got %h expected %h", name, got, exp);
    end
  endtask

  // One APB transfer with a setup phase and then access until pready
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          output apb_rsp_t rsp, output int waits);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    waits = 0;
    @(negedge clk);
    while (apb_rsp.pready !== 1'b1) begin
      waits++;  // Slave inserted a wait state
      @(negedge clk);
    end
    rsp = apb_rsp;
    @(posedge clk);
    apb_req <= '0;  // Back to idle after the completing edge
  endtask

  task automatic reg_write(input string name, input logic [11:0] addr, input logic [31:0] wdata,
                           input logic exp_err);
    apb_rsp_t rsp;
    apb_rsp_t exp;
    int       waits;
    exp = '{pready: 1'b1, pslverr: exp_err, prdata: 32'h0};
    apb_xfer(1'b1, addr, wdata, rsp, waits);
    check_apb_rsp(name, rsp, exp, 1'b0);
    check_waits(name, waits, 0);  // Writes never wait
  endtask

  task automatic reg_read(input string name, input logic [11:0] addr, input logic [31:0] exp_data,
                          input logic exp_err, input int exp_waits);
    apb_rsp_t rsp;
    apb_rsp_t exp;
    int       waits;
    exp = '{pready: 1'b1, pslverr: exp_err, prdata: exp_data};
    apb_xfer(1'b0, addr, 32'h0, rsp, waits);
    check_apb_rsp(name, rsp, exp, !exp_err);
    check_waits(name, waits, exp_waits);
  endtask

  task automatic load_word(input logic [12:0] ua, input cs_word_u w);
    reg_write("addr set", REG_ADDR, addr_value(ua, 2'd0), 1'b0);
    for (int i = 0; i < N_LANES; i++) begin
      reg_write($sformatf("data lane %0d", i), REG_DATA, {16'h0, w.lanes[i]}, 1'b0);
    end
  endtask

  // Back to back fetches with each response one cycle after its request
  task automatic fetch_run(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      fetch_req <= '{valid: 1'b1, ua: fetch_ua[i]};
      @(negedge clk);
      if (i == 0 && fetch_rsp.valid !== 1'b0) begin
        errors++;
        $display("%s: fetch response showed up in the request cycle", test_name);
      end else if (i > 0) begin
        fetch_got[i-1] = fetch_rsp;
      end
    end
    @(posedge clk);
    fetch_req <= '0;
    @(negedge clk);
    fetch_got[n-1] = fetch_rsp;
    @(negedge clk);
    if (fetch_rsp.valid !== 1'b0) begin
      errors++;
      $display("%s: fetch response still valid after the last request", test_name);
    end
  endtask

  task automatic begin_test(input string name);
    test_name    = name;
    err_at_start = errors;
    tests++;
  endtask

  task automatic end_test();
    if (errors == err_at_start) begin
      $display("%-20s ok", test_name);
    end else begin
      $display("%-20s %0d errors", test_name, errors - err_at_start);
    end
  endtask

  `include "wcs_tb_tests.svh"

  initial begin
    rst       <= 1'b1;
    apb_req   <= '0;
    fetch_req <= '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_reset_state();
    test_lane_load();
    test_bank_split();
    test_readback();
    test_protection();
    test_addr_wrap();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+verification
hdl/wcs_pkg.sv
hdl/wcs_bank.sv
hdl/wcs_store.sv
hdl/wcs_addr_counter.sv
hdl/wcs_load_fsm.sv
hdl/wcs_top.sv
verification/wcs_tb.sv

// File: Makefile
# Verilator build and run for the writable control store testbench

VERILATOR ?= verilator
TOP       ?= wcs_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
